// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    localparam int WORD_W = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [1:0]        reg_idx_t;

    localparam word_t    RESET_PC_DEFAULT = 16'h0000;
    localparam reg_idx_t LINK_REG         = 2'd2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        OP_BNE = 4'd0,
        OP_BEQ = 4'd1,
        OP_BGZ = 4'd2,
        OP_BLZ = 4'd3,
        OP_ADI = 4'd4,
        OP_ORI = 4'd5,
        OP_LHI = 4'd6,
        OP_LWD = 4'd7,
        OP_SWD = 4'd8,
        OP_JMP = 4'd9,
        OP_JAL = 4'd10,
        OP_ALU = 4'd15         // Also JPR, JRL and HLT by function code.
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADD = 6'd0,
        F_SUB = 6'd1,
        F_AND = 6'd2,
        F_ORR = 6'd3,
        F_NOT = 6'd4,
        F_TCP = 6'd5,
        F_SHL = 6'd6,
        F_SHR = 6'd7,
        F_JPR = 6'd25,
        F_JRL = 6'd26,
        F_HLT = 6'd29
    } func_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR
    } alu_op_e;

    typedef enum logic [1:0] {
        DEST_RD,
        DEST_RT,
        DEST_LINK
    } dest_e;

    typedef struct packed {
        logic    alu_src;      // Second ALU operand is the immediate.
        alu_op_e alu_op;
        logic    reg_write;
        logic    mem_read;
        logic    mem_to_reg;
        logic    mem_write;
        logic    pc_to_reg;
        logic    jump;
        logic    jump_reg;
        logic    branch;
        logic    halt;
        dest_e   dest_sel;
    } ctrl_t;

    // Wishbone classic, one word per cycle.
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    function automatic opcode_e opcode_of(word_t instr);
        return opcode_e'(instr[15:12]);
    endfunction

    function automatic func_e func_of(word_t instr);
        return func_e'(instr[5:0]);
    endfunction

    function automatic reg_idx_t rs_of(word_t instr);
        return instr[11:10];
    endfunction

    function automatic reg_idx_t rt_of(word_t instr);
        return instr[9:8];
    endfunction

    function automatic reg_idx_t rd_of(word_t instr);
        return instr[7:6];
    endfunction

    function automatic logic [7:0] imm_of(word_t instr);
        return instr[7:0];
    endfunction

endpackage

// ==== design/control_unit.sv ====
`timescale 1ns/10ps

module control_unit import cpu_pkg::*; (
    input  word_t instr,
    output ctrl_t ctrl
);

    logic    is_rtype;
    logic    is_itype;
    logic    is_load;
    logic    is_store;
    logic    is_branch;
    logic    is_jump;
    logic    is_jreg;
    logic    is_link;
    logic    is_halt;
    alu_op_e op;

    always_comb begin
        is_rtype  = 1'b0;
        is_itype  = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        is_jreg   = 1'b0;
        is_link   = 1'b0;
        is_halt   = 1'b0;
        op        = ALU_ADD;
        case (opcode_of(instr))
            OP_ALU: begin
                case (func_of(instr))
                    F_ADD: begin is_rtype = 1'b1; op = ALU_ADD; end
                    F_SUB: begin is_rtype = 1'b1; op = ALU_SUB; end
                    F_AND: begin is_rtype = 1'b1; op = ALU_AND; end
                    F_ORR: begin is_rtype = 1'b1; op = ALU_OR;  end
                    F_NOT: begin is_rtype = 1'b1; op = ALU_NOT; end
                    F_TCP: begin is_rtype = 1'b1; op = ALU_TCP; end
                    F_SHL: begin is_rtype = 1'b1; op = ALU_SHL; end
                    F_SHR: begin is_rtype = 1'b1; op = ALU_SHR; end
                    F_JPR: is_jreg = 1'b1;
                    F_JRL: begin is_jreg = 1'b1; is_link = 1'b1; end
                    F_HLT: is_halt = 1'b1;
                    default: ;
                endcase
            end
            OP_ADI: begin is_itype = 1'b1; op = ALU_ADD; end
            OP_ORI: begin is_itype = 1'b1; op = ALU_OR; end
            OP_LHI: begin is_itype = 1'b1; op = ALU_OR; end     // The core zeroes operand a.
            OP_LWD: begin is_load = 1'b1; op = ALU_ADD; end
            OP_SWD: begin is_store = 1'b1; op = ALU_ADD; end
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
                is_branch = 1'b1;
                op        = ALU_SUB;
            end
            OP_JMP: is_jump = 1'b1;
            OP_JAL: begin is_jump = 1'b1; is_link = 1'b1; end
            default: ;
        endcase
    end

    always_comb begin
        ctrl            = '0;
        ctrl.alu_src    = is_itype | is_load | is_store;
        ctrl.alu_op     = op;
        ctrl.reg_write  = is_rtype | is_itype | is_load | is_link;
        ctrl.mem_read   = is_load;
        ctrl.mem_to_reg = is_load;
        ctrl.mem_write  = is_store;
        ctrl.pc_to_reg  = is_link;
        ctrl.jump       = is_jump;
        ctrl.jump_reg   = is_jreg;
        ctrl.branch     = is_branch;
        ctrl.halt       = is_halt;
        if (is_rtype)
            ctrl.dest_sel = DEST_RD;
        else if (is_link)
            ctrl.dest_sel = DEST_LINK;
        else
            ctrl.dest_sel = DEST_RT;
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    zero,
    output logic    negative
);

    word_t diff;

    assign diff = a - b;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_NOT: result = ~a;
            ALU_TCP: result = ~a + 16'd1;
            ALU_SHL: result = {a[14:0], 1'b0};
            ALU_SHR: result = {a[15], a[15:1]};  // Arithmetic, the sign bit stays.
            default: result = '0;
        endcase
    end

    assign zero     = (diff == '0);   // Equality of a and b for BEQ and BNE.
    assign negative = a[15];

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit import cpu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    fetch_req,
    input  word_t   fetch_adr,
    output logic    instr_valid,
    output word_t   instr,
    output wb_req_t wb_out,
    input  wb_rsp_t wb_in
);

    logic  busy;
    word_t adr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy        <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            if (!busy && fetch_req) begin
                busy <= 1'b1;
            end else if (busy && wb_in.ack) begin
                busy        <= 1'b0;             // Cycle drops right after ack.
                instr_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && fetch_req)
            adr_q <= fetch_adr;
        if (busy && wb_in.ack)
            instr <= wb_in.dat;
    end

    assign wb_out = '{cyc: busy, stb: busy, we: 1'b0, adr: adr_q, dat: '0};

endmodule

// ==== design/load_store_unit.sv ====
`timescale 1ns/10ps

module load_store_unit import cpu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    mem_req,
    input  logic    mem_we,
    input  word_t   mem_adr,
    input  word_t   mem_wdata,
    output logic    mem_done,
    output word_t   mem_rdata,
    output wb_req_t wb_out,
    input  wb_rsp_t wb_in
);

    logic  busy;
    logic  we_q;
    word_t adr_q;
    word_t wdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (!busy && mem_req) begin
                busy <= 1'b1;
            end else if (busy && wb_in.ack) begin
                busy     <= 1'b0;
                mem_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && mem_req) begin
            we_q    <= mem_we;
            adr_q   <= mem_adr;
            wdata_q <= mem_wdata;
        end
        if (busy && wb_in.ack)
            mem_rdata <= wb_in.dat;          // Only meaningful for a read.
    end

    assign wb_out = '{cyc: busy, stb: busy, we: we_q, adr: adr_q, dat: wdata_q};

endmodule

// ==== design/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter import cpu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  wb_req_t fetch_bus,
    input  wb_req_t data_bus,
    output wb_rsp_t fetch_rsp,
    output wb_rsp_t data_rsp,
    output wb_req_t mem_bus,
    input  wb_rsp_t mem_rsp
);

    logic grant_data_q;
    logic grant_data;
    logic hold;

    // The owner of the last cycle keeps the port while its cyc stays high.
    always_comb begin
        hold       = grant_data_q ? data_bus.cyc : fetch_bus.cyc;
        grant_data = hold ? grant_data_q : data_bus.cyc;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            grant_data_q <= 1'b0;
        else
            grant_data_q <= grant_data;
    end

    assign mem_bus = grant_data ? data_bus : fetch_bus;

    // Read data goes to both sides, ack only to the owner.
    assign fetch_rsp = '{ack: mem_rsp.ack & ~grant_data, dat: mem_rsp.dat};
    assign data_rsp  = '{ack: mem_rsp.ack & grant_data, dat: mem_rsp.dat};

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core import cpu_pkg::*; #(
    parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
    input  logic  clk,
    input  logic  arst_n,
    output logic  fetch_req,
    output word_t fetch_adr,
    input  logic  instr_valid,
    input  word_t instr,
    output logic  mem_req,
    output logic  mem_we,
    output word_t mem_adr,
    output word_t mem_wdata,
    input  logic  mem_done,
    input  word_t mem_rdata
);

    typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WB, HALTED} state_e;

    state_e      state;
    logic        req_sent;
    word_t       pc;
    word_t       ir;
    word_t [3:0] regs;
    word_t       reg_a;
    word_t       reg_b;
    word_t       alu_out;
    word_t       mem_data;

    ctrl_t       ctrl;
    opcode_e     opcode;
    logic        sign_test;
    word_t       imm_ext;
    word_t       alu_a;
    word_t       alu_b;
    word_t       alu_result;
    logic        zero;
    logic        negative;
    logic        take_branch;
    word_t       pc_inc;
    word_t       next_pc;
    word_t       wb_value;
    reg_idx_t    wb_dest;

    control_unit u_ctrl (
        .instr (ir),
        .ctrl  (ctrl)
    );

    alu u_alu (
        .op       (ctrl.alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .result   (alu_result),
        .zero     (zero),
        .negative (negative)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operands, next PC and write-back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opcode    = opcode_of(ir);
    assign sign_test = (opcode == OP_BGZ) || (opcode == OP_BLZ);
    assign pc_inc    = pc + 16'd1;

    always_comb begin
        case (opcode)
            OP_ORI:  imm_ext = {8'h00, imm_of(ir)};
            OP_LHI:  imm_ext = {imm_of(ir), 8'h00};
            default: imm_ext = {{8{ir[7]}}, imm_of(ir)};
        endcase
    end

    assign alu_a = (opcode == OP_LHI) ? '0 : reg_a;
    assign alu_b = ctrl.alu_src ? imm_ext : reg_b;

    always_comb begin
        case (opcode)
            OP_BNE:  take_branch = !zero;
            OP_BEQ:  take_branch = zero;
            OP_BGZ:  take_branch = !negative && !zero;   // reg_b is zero here.
            OP_BLZ:  take_branch = negative;
            default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.jump_reg)
            next_pc = reg_a;
        else if (ctrl.jump)
            next_pc = {pc_inc[15:12], ir[11:0]};
        else if (ctrl.branch && take_branch)
            next_pc = pc_inc + imm_ext;
        else
            next_pc = pc_inc;
    end

    always_comb begin
        case (ctrl.dest_sel)
            DEST_RT:   wb_dest = rt_of(ir);
            DEST_LINK: wb_dest = LINK_REG;
            default:   wb_dest = rd_of(ir);
        endcase
    end

    assign wb_value  = ctrl.mem_to_reg ? mem_data : alu_out;
    assign fetch_adr = pc;
    assign mem_adr   = alu_out;
    assign mem_wdata = reg_b;
    assign mem_we    = ctrl.mem_write;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= FETCH;
            req_sent  <= 1'b0;
            pc        <= RESET_PC;
            regs      <= '0;
            fetch_req <= 1'b0;
            mem_req   <= 1'b0;
        end else begin
            fetch_req <= 1'b0;
            mem_req   <= 1'b0;
            case (state)
                FETCH: begin
                    if (!req_sent) begin
                        fetch_req <= 1'b1;
                        req_sent  <= 1'b1;
                    end else if (instr_valid) begin
                        req_sent <= 1'b0;
                        state    <= DECODE;
                    end
                end
                DECODE: state <= EXEC;
                EXEC: begin
                    if (ctrl.halt) begin
                        state <= HALTED;
                    end else begin
                        pc    <= next_pc;
                        state <= (ctrl.mem_read || ctrl.mem_write) ? MEM : WB;
                    end
                end
                MEM: begin
                    if (!req_sent) begin
                        mem_req  <= 1'b1;
                        req_sent <= 1'b1;
                    end else if (mem_done) begin
                        req_sent <= 1'b0;
                        state    <= WB;
                    end
                end
                WB: begin
                    if (ctrl.reg_write)
                        regs[wb_dest] <= wb_value;
                    state <= FETCH;
                end
                HALTED: state <= HALTED;       // No more bus cycles.
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && instr_valid)
            ir <= instr;
        if (state == DECODE) begin
            reg_a <= regs[rs_of(ir)];
            reg_b <= sign_test ? '0 : regs[rt_of(ir)];
        end
        if (state == EXEC)
            alu_out <= ctrl.pc_to_reg ? pc_inc : alu_result;    // Link value for JAL and JRL.
        if (state == MEM && mem_done)
            mem_data <= mem_rdata;
    end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
    input  logic    clk,
    input  logic    arst_n,
    output wb_req_t mem_bus,
    input  wb_rsp_t mem_rsp
);

    logic    fetch_req;
    word_t   fetch_adr;
    logic    instr_valid;
    word_t   instr;
    logic    mem_req;
    logic    mem_we;
    word_t   mem_adr;
    word_t   mem_wdata;
    logic    mem_done;
    word_t   mem_rdata;
    wb_req_t fetch_bus;
    wb_req_t data_bus;
    wb_rsp_t fetch_rsp;
    wb_rsp_t data_rsp;

    cpu_core #(
        .RESET_PC (RESET_PC)
    ) u_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_req   (fetch_req),
        .fetch_adr   (fetch_adr),
        .instr_valid (instr_valid),
        .instr       (instr),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_adr     (mem_adr),
        .mem_wdata   (mem_wdata),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata)
    );

    fetch_unit u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_req   (fetch_req),
        .fetch_adr   (fetch_adr),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_out      (fetch_bus),
        .wb_in       (fetch_rsp)
    );

    load_store_unit u_lsu (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_wdata (mem_wdata),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .wb_out    (data_bus),
        .wb_in     (data_rsp)
    );

    bus_arbiter u_arb (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch_bus (fetch_bus),
        .data_bus  (data_bus),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .mem_bus   (mem_bus),
        .mem_rsp   (mem_rsp)
    );

endmodule

// ==== testbench/tb_tests.svh ====
task automatic test_rtype();
    word_t a;
    word_t b;
    word_t expect_val [8];
    a = 16'h5a3c;                                      // MSB clear so both shifts agree.
    b = 16'h1234;
    expect_val = '{a + b, a - b, a & b, a | b, ~a, 16'd0 - a, a << 1, a >> 1};
    start_program();
    preset(8'h40, a);
    preset(8'h41, b);
    emit(i_enc(OP_LWD, R0, R1, 8'h40));
    emit(i_enc(OP_LWD, R0, R2, 8'h41));
    for (int k = 0; k < 8; k++) begin
        emit(r_enc(func_e'(6'(k)), R1, R2, R3));
        emit(i_enc(OP_SWD, R0, R3, 8'h50 + 8'(k)));
    end
    emit(HLT_WORD);
    run_program();
    for (int k = 0; k < 8; k++)
        check_word($sformatf("rtype func %0d", k), expect_val[k], mem[8'h50 + 8'(k)]);
endtask

task automatic test_immediates();
    word_t neg_sum;
    neg_sum = 16'd0 + sext8(8'hF6) + sext8(8'h85);
    start_program();
    emit(i_enc(OP_ADI, R0, R1, 8'hF6));
    emit(i_enc(OP_ADI, R1, R1, 8'h85));
    emit(i_enc(OP_SWD, R0, R1, 8'h40));
    emit(i_enc(OP_ORI, R0, R2, 8'hA5));
    emit(i_enc(OP_SWD, R0, R2, 8'h41));
    emit(i_enc(OP_ORI, R1, R3, 8'h80));
    emit(i_enc(OP_SWD, R0, R3, 8'h42));
    emit(i_enc(OP_LHI, R1, R2, 8'h9C));
    emit(i_enc(OP_SWD, R0, R2, 8'h43));
    emit(i_enc(OP_ORI, R2, R2, 8'h3E));
    emit(i_enc(OP_SWD, R0, R2, 8'h44));
    emit(HLT_WORD);
    run_program();
    check_word("adi negative", neg_sum, mem[8'h40]);
    check_word("ori zero extend", {8'h00, 8'hA5}, mem[8'h41]);
    check_word("ori on negative", neg_sum | {8'h00, 8'h80}, mem[8'h42]);
    check_word("lhi", {8'h9C, 8'h00}, mem[8'h43]);
    check_word("lhi then ori", {8'h9C, 8'h3E}, mem[8'h44]);
endtask

task automatic build_memory_program();
    preset(8'h40, 16'h1357);
    preset(8'h41, 16'h2468);
    preset(8'h42, 16'h0050);                           // Base pointer for the stores.
    emit(i_enc(OP_LWD, R0, R1, 8'h40));
    emit(i_enc(OP_LWD, R0, R2, 8'h41));
    emit(i_enc(OP_LWD, R0, R3, 8'h42));
    emit(r_enc(F_ADD, R1, R2, R0));
    emit(i_enc(OP_SWD, R3, R0, 8'h03));
    emit(r_enc(F_SUB, R2, R1, R1));
    emit(i_enc(OP_SWD, R3, R1, 8'hFE));
    emit(i_enc(OP_SWD, R3, R2, 8'h00));
    emit(i_enc(OP_LWD, R3, R1, 8'hF0));
    emit(i_enc(OP_SWD, R3, R1, 8'h05));
    emit(HLT_WORD);
endtask

task automatic test_loads_stores();
    word_t p;
    word_t q;
    p = 16'h1357;
    q = 16'h2468;
    start_program();
    build_memory_program();
    run_program();
    check_word("store base+3", p + q, mem[8'h53]);
    check_word("store base-2", q - p, mem[8'h4E]);
    check_word("store base+0", q, mem[8'h50]);
    check_word("load base-16", p, mem[8'h55]);
    check_word("untouched 0x4F", 16'h0000, mem[8'h4F]);
    check_word("untouched 0x52", 16'h0000, mem[8'h52]);
    check_word("untouched 0x54", 16'h0000, mem[8'h54]);
endtask

task automatic test_branches();
    word_t    v [4];
    logic     taken [8];
    opcode_e  br_op [8];
    reg_idx_t br_rs [8];
    reg_idx_t br_rt [8];
    v     = '{16'd0, 16'd5, 16'd5, sext8(8'hFD)};
    br_op = '{OP_BNE, OP_BNE, OP_BEQ, OP_BEQ, OP_BGZ, OP_BGZ, OP_BLZ, OP_BLZ};
    br_rs = '{R1, R1, R1, R1, R1, R3, R3, R0};
    br_rt = '{R2, R3, R2, R0, R2, R2, R2, R2};
    taken = '{v[1] != v[2], v[1] != v[3], v[1] == v[2], v[1] == v[0],
              !v[1][15] && v[1] != 16'd0, !v[3][15] && v[3] != 16'd0, v[3][15], v[0][15]};
    start_program();
    emit(i_enc(OP_ADI, R0, R1, 8'h05));
    emit(i_enc(OP_ADI, R0, R2, 8'h05));
    emit(i_enc(OP_ADI, R0, R3, 8'hFD));
    for (int k = 0; k < 8; k++) begin
        emit(i_enc(br_op[k], br_rs[k], br_rt[k], 8'h01));   // A taken branch skips the store.
        emit(i_enc(OP_SWD, R0, R1, 8'h40 + 8'(k)));
    end
    emit(i_enc(OP_SWD, R0, R1, 8'h4F));
    emit(HLT_WORD);
    run_program();
    for (int k = 0; k < 8; k++)
        check_word($sformatf("branch case %0d", k), taken[k] ? 16'd0 : v[1],
                   mem[8'h40 + 8'(k)]);
    check_word("branch fall through", v[1], mem[8'h4F]);
endtask

task automatic test_jumps();
    word_t jal_pc;
    word_t jrl_pc;
    start_program();
    emit(i_enc(OP_ADI, R0, R1, 8'h2A));
    emit(j_enc(OP_JMP, 12'h003));
    emit(i_enc(OP_SWD, R0, R1, 8'h40));
    emit(i_enc(OP_ADI, R0, R3, 8'h06));
    emit(r_enc(F_JPR, R3, R0, R0));
    emit(i_enc(OP_SWD, R0, R1, 8'h41));
    jal_pc = 16'(prog_len);
    emit(j_enc(OP_JAL, 12'h009));
    emit(i_enc(OP_SWD, R0, R1, 8'h42));
    emit(i_enc(OP_SWD, R0, R1, 8'h43));
    emit(i_enc(OP_SWD, R0, R2, 8'h44));
    emit(i_enc(OP_ADI, R0, R3, 8'h0D));
    jrl_pc = 16'(prog_len);
    emit(r_enc(F_JRL, R3, R0, R0));
    emit(i_enc(OP_SWD, R0, R1, 8'h45));
    emit(i_enc(OP_SWD, R0, R2, 8'h46));
    emit(i_enc(OP_SWD, R0, R1, 8'h47));
    emit(HLT_WORD);
    run_program();
    check_word("jmp skip", 16'd0, mem[8'h40]);
    check_word("jpr skip", 16'd0, mem[8'h41]);
    check_word("jal skip 1", 16'd0, mem[8'h42]);
    check_word("jal skip 2", 16'd0, mem[8'h43]);
    check_word("jal link", jal_pc + 16'd1, mem[8'h44]);
    check_word("jrl skip", 16'd0, mem[8'h45]);
    check_word("jrl link", jrl_pc + 16'd1, mem[8'h46]);
    check_word("after jumps", 16'h002A, mem[8'h47]);
endtask

task automatic test_halt_and_waits();
    word_t first_run [64];
    start_program();
    build_memory_program();
    emit(i_enc(OP_SWD, R3, R2, 8'h10));                // Lies after HLT and must not run.
    run_program();
    for (int i = 0; i < 64; i++)
        first_run[i] = mem[8'h40 + 8'(i)];
    check_word("no store after hlt", 16'd0, mem[8'h60]);
    run_program();
    for (int i = 0; i < 64; i++)
        check_word($sformatf("rerun word %0d", 16'h40 + i), first_run[i], mem[8'h40 + 8'(i)]);
endtask

// ==== testbench/tb_cpu_top.sv ====
`timescale 1ns/10ps

module tb_cpu_top import cpu_pkg::*; ();

    localparam logic [31:0] LFSR_SEED = 32'h9167762b;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam word_t       HLT_WORD  = {OP_ALU, 6'd0, F_HLT};
    localparam reg_idx_t    R0        = 2'd0;
    localparam reg_idx_t    R1        = 2'd1;
    localparam reg_idx_t    R2        = 2'd2;
    localparam reg_idx_t    R3        = 2'd3;

    logic        clk     = 1'b0;
    logic        arst_n;
    wb_req_t     mem_bus;
    wb_rsp_t     mem_rsp = '0;

    word_t       image [256];                  // Loaded into memory while reset is held.
    word_t       mem [256];
    int          prog_len;
    int          cycle_budget = 0;
    logic [31:0] lfsr = LFSR_SEED;
    logic [1:0]  wait_left;
    logic        pending;
    logic        hlt_seen;
    int          idle_cycles;

    cpu_top #(
        .RESET_PC (16'h0000)
    ) UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .mem_bus (mem_bus),
        .mem_rsp (mem_rsp)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic word_t r_enc(func_e f, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
        return {OP_ALU, rs, rt, rd, f};
    endfunction

    function automatic word_t i_enc(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_enc(opcode_e op, logic [11:0] target);
        return {op, target};
    endfunction

    function automatic word_t sext8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
            fail_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    // Code at the bottom, a cleared data area at 0x40 to 0x7F, and a fill
    // of undefined opcodes elsewhere that runs off the end of memory.
    task automatic start_program();
        prog_len = 0;
        for (int i = 0; i < 256; i++)
            image[i] = (i >= 'h40 && i < 'h80) ? 16'h0000 : (16'hE000 | 16'(i));
    endtask

    task automatic emit(input word_t w);
        image[prog_len] = w;
        prog_len++;
    endtask

    task automatic preset(input logic [7:0] adr, input word_t value);
        image[adr] = value;
    endtask

    task automatic run_program();
        cycle_budget += 200 * prog_len;
        @(negedge clk);
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        while (!(hlt_seen && idle_cycles >= 20))
            @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory model with random ack delay
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < 256; i++)
                mem[i] = image[i];
            mem_rsp     = '0;
            pending     = 1'b0;
            hlt_seen    = 1'b0;
            idle_cycles = 0;
        end else begin
            if (mem_bus.cyc)
                idle_cycles = 0;
            else if (idle_cycles < 1000)
                idle_cycles++;
            if (mem_rsp.ack || !(mem_bus.cyc && mem_bus.stb)) begin
                mem_rsp.ack = 1'b0;                // The ack lasts one cycle.
            end else begin
                if (hlt_seen)
                    fail_run("A bus request appeared after HLT was fetched.");
                if (mem_bus.adr > 16'd255)
                    fail_run("A bus cycle addressed a word outside the memory.");
                if (!pending) begin
                    wait_left[0] = lfsr[0];
                    lfsr         = lfsr_next(lfsr);
                    wait_left[1] = lfsr[0];
                    lfsr         = lfsr_next(lfsr);
                    pending      = 1'b1;
                end
                if (wait_left == 2'd0) begin
                    pending     = 1'b0;
                    mem_rsp.ack = 1'b1;
                    if (mem_bus.we) begin
                        mem[mem_bus.adr[7:0]] = mem_bus.dat;
                    end else begin
                        mem_rsp.dat = mem[mem_bus.adr[7:0]];
                        if (mem_rsp.dat == HLT_WORD)
                            hlt_seen = 1'b1;
                    end
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_budget)
                fail_run($sformatf("Timeout after %0d cycles without the program halting.",
                                   cycles));
        end
    end

    `include "tb_tests.svh"

    initial begin
        arst_n = 1'b0;
        test_rtype();
        test_immediates();
        test_loads_stores();
        test_branches();
        test_jumps();
        test_halt_and_waits();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+testbench
design/cpu_pkg.sv
design/control_unit.sv
design/alu.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/bus_arbiter.sv
design/cpu_core.sv
design/cpu_top.sv
testbench/tb_cpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure.

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_cpu_top -Mdir obj_dir -o tb_cpu_top -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/tb_cpu_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qx "tests failed" "$LOG"; then
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

exit 0
